// File: files.f
hdl/ncpu32k_pkg.sv
hdl/ncpu32k_issue_if.sv
hdl/ncpu32k_pipebuf.sv
hdl/ncpu32k_regfile.sv
hdl/ncpu32k_div_fsm.sv
hdl/ncpu32k_div_cnt.sv
hdl/ncpu32k_div_dp.sv
hdl/ncpu32k_idu.sv
hdl/ncpu32k_ieu.sv
hdl/ncpu32k_core.sv
tests/ncpu32k_core_sva.sv
tests/tb_ncpu32k_core.sv

// File: hdl/ncpu32k_core.sv
// Decode/execute slice top level. Instruction words enter with a
// valid/ready handshake; each retirement pulses retire_o.
module ncpu32k_core (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   insn_valid_i,
   output logic                   insn_ready_o,
   input  ncpu32k_pkg::insn_t     insn_i,
   input  logic                   flush_i,
   output logic                   retire_o,
   output logic                   wb_valid_o,
   output ncpu32k_pkg::reg_addr_t wb_addr_o,
   output ncpu32k_pkg::word_t     wb_data_o
);
   import ncpu32k_pkg::*;

   logic rs1_re;
   logic rs2_re;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   word_t rs1_dout;
   word_t rs2_dout;

   ncpu32k_issue_if issue ();

   ncpu32k_idu idu (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .idu_in_valid_i  (insn_valid_i),
      .idu_in_ready_o  (insn_ready_o),
      .idu_insn_i      (insn_i),
      .specul_flush_i  (flush_i),
      .regf_rs1_re_o   (rs1_re),
      .regf_rs1_addr_o (rs1_addr),
      .regf_rs1_dout_i (rs1_dout),
      .regf_rs2_re_o   (rs2_re),
      .regf_rs2_addr_o (rs2_addr),
      .regf_rs2_dout_i (rs2_dout),
      .issue           (issue.idu)
   );

   ncpu32k_regfile regfile (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .rs1_re_i   (rs1_re),
      .rs1_addr_i (rs1_addr),
      .rs1_dout_o (rs1_dout),
      .rs2_re_i   (rs2_re),
      .rs2_addr_i (rs2_addr),
      .rs2_dout_o (rs2_dout),
      .we_i       (wb_valid_o),
      .waddr_i    (wb_addr_o),
      .wdata_i    (wb_data_o)
   );

   ncpu32k_ieu ieu (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .issue        (issue.ieu),
      .regf_we_o    (wb_valid_o),
      .regf_waddr_o (wb_addr_o),
      .regf_wdata_o (wb_data_o),
      .retire_o     (retire_o)
   );

endmodule

// File: hdl/ncpu32k_div_cnt.sv
// Divider iteration counter. Loaded on start, last_o flags the final
// of ncpu_dw iterations.
module ncpu32k_div_cnt (
   input  logic clk,
   input  logic arst_n_i,
   input  logic start_i,
   output logic last_o
);
   import ncpu32k_pkg::*;

   div_cnt_t cnt;
   logic running;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt <= '0;
         running <= 1'b0;
      end else if (start_i) begin
         cnt <= div_cnt_t'(ncpu_dw - 1);
         running <= 1'b1;
      end else if (running) begin
         if (cnt == '0)
            running <= 1'b0;
         else
            cnt <= cnt - 1'b1;
      end
   end

   assign last_o = running & (cnt == '0);

endmodule

// File: hdl/ncpu32k_div_dp.sv
// Restoring shift-subtract divider on magnitudes with sign correction.
// Results are valid once ncpu_dw iterations have passed since start_i.
module ncpu32k_div_dp (
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic               start_i,
   input  logic               signed_i,
   input  ncpu32k_pkg::word_t dividend_i,
   input  ncpu32k_pkg::word_t divisor_i,
   output ncpu32k_pkg::word_t quotient_o,
   output ncpu32k_pkg::word_t remainder_o
);
   import ncpu32k_pkg::*;

   logic dvd_neg;
   logic dvs_neg;
   word_t quo_r;
   word_t rem_r;
   word_t dvs_r;
   logic [ncpu_dw:0] shifted;
   logic [ncpu_dw:0] trial;
   logic neg_q_r;
   logic neg_r_r;
   logic dvz_r;

   assign dvd_neg = signed_i & dividend_i[ncpu_dw-1];
   assign dvs_neg = signed_i & divisor_i[ncpu_dw-1];
   assign shifted = {rem_r, quo_r[ncpu_dw-1]};
   assign trial = shifted - {1'b0, dvs_r};

   // Steps every cycle; the owner reads the result in the done cycle
   always_ff @(posedge clk) begin
      if (start_i) begin
         quo_r <= dvd_neg ? -dividend_i : dividend_i;
         dvs_r <= dvs_neg ? -divisor_i : divisor_i;
         rem_r <= '0;
      end else if (!trial[ncpu_dw]) begin
         rem_r <= trial[ncpu_dw-1:0];
         quo_r <= {quo_r[ncpu_dw-2:0], 1'b1};
      end else begin
         rem_r <= shifted[ncpu_dw-1:0];
         quo_r <= {quo_r[ncpu_dw-2:0], 1'b0};
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         neg_q_r <= 1'b0;
         neg_r_r <= 1'b0;
         dvz_r <= 1'b0;
      end else if (start_i) begin
         neg_q_r <= dvd_neg ^ dvs_neg;
         neg_r_r <= dvd_neg;
         dvz_r <= divisor_i == '0;
      end
   end

   // Zero divisor: all ones, remainder falls out as the dividend
   assign quotient_o = dvz_r ? '1 : (neg_q_r ? -quo_r : quo_r);
   assign remainder_o = neg_r_r ? -rem_r : rem_r;

endmodule

// File: hdl/ncpu32k_div_fsm.sv
// Divider control. One start cycle, run until the counter's last
// iteration, then a single done cycle.
module ncpu32k_div_fsm (
   input  logic clk,
   input  logic arst_n_i,
   input  logic req_i,
   input  logic last_i,
   output logic start_o,
   output logic busy_o,
   output logic done_o
);
   import ncpu32k_pkg::*;

   div_state_e state;
   div_state_e state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         div_idle: if (req_i) state_nxt = div_run;
         div_run:  if (last_i) state_nxt = div_done;
         div_done: state_nxt = div_idle;
         default:  state_nxt = div_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state <= div_idle;
      end else begin
         state <= state_nxt;
      end
   end

   assign start_o = (state == div_idle) & req_i;
   assign busy_o = state != div_idle;
   assign done_o = state == div_done;

endmodule

// File: hdl/ncpu32k_idu.sv
// Instruction decode unit. Splits the instruction word, requests source
// registers and registers the decoded operation for the execute unit.
module ncpu32k_idu (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   idu_in_valid_i,
   output logic                   idu_in_ready_o,
   input  ncpu32k_pkg::insn_t     idu_insn_i,
   input  logic                   specul_flush_i,
   output logic                   regf_rs1_re_o,
   output ncpu32k_pkg::reg_addr_t regf_rs1_addr_o,
   input  ncpu32k_pkg::word_t     regf_rs1_dout_i,
   output logic                   regf_rs2_re_o,
   output ncpu32k_pkg::reg_addr_t regf_rs2_addr_o,
   input  ncpu32k_pkg::word_t     regf_rs2_dout_i,
   ncpu32k_issue_if.idu           issue
);
   import ncpu32k_pkg::*;

   logic [opc_w-1:0] opcode;
   logic [imm14_w-1:0] imm14;
   logic [imm18_w-1:0] imm18;
   lu_opc_t lu_opc;
   au_opc_t au_opc;
   logic insn_imm14;
   logic insn_imm18;
   logic imm14_signed;
   logic rs1_use;
   logic rs2_use;
   logic insn_known;
   logic cas;
   word_t imm_nxt;
   word_t imm_r;
   logic rs1_frm_regf_r;
   logic rs2_frm_regf_r;

   assign opcode = idu_insn_i[opc_lsb +: opc_w];
   assign imm14 = idu_insn_i[imm14_lsb +: imm14_w];
   assign imm18 = idu_insn_i[imm18_lsb +: imm18_w];

   assign lu_opc[lu_and] = opcode inside {op_and, op_and_i};
   assign lu_opc[lu_or] = opcode inside {op_or, op_or_i};
   assign lu_opc[lu_xor] = opcode inside {op_xor, op_xor_i};
   assign lu_opc[lu_lsl] = opcode inside {op_lsl, op_lsl_i};
   assign lu_opc[lu_lsr] = opcode inside {op_lsr, op_lsr_i};
   assign lu_opc[lu_asr] = opcode inside {op_asr, op_asr_i};

   assign au_opc[au_add] = opcode inside {op_add, op_add_i};
   assign au_opc[au_sub] = opcode == op_sub;
   assign au_opc[au_mhi] = opcode == op_mhi;
   assign au_opc[au_div] = opcode == op_div;
   assign au_opc[au_divu] = opcode == op_divu;
   assign au_opc[au_mod] = opcode == op_mod;
   assign au_opc[au_modu] = opcode == op_modu;

   assign insn_known = |lu_opc | |au_opc;

   // rs1 plus immediate forms
   assign insn_imm14 = opcode inside {op_and_i, op_or_i, op_xor_i, op_lsl_i, op_lsr_i,
                                      op_asr_i, op_add_i};
   assign imm14_signed = opcode inside {op_and_i, op_xor_i, op_add_i};
   // MHI has no register source
   assign insn_imm18 = au_opc[au_mhi];

   always_comb begin
      if (insn_imm18)
         imm_nxt = word_t'(imm18);
      else if (imm14_signed)
         imm_nxt = {{(ncpu_dw-imm14_w){imm14[imm14_w-1]}}, imm14};
      else
         imm_nxt = word_t'(imm14);
   end

   ncpu32k_pipebuf pipebuf (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (idu_in_valid_i),
      .in_ready_o  (idu_in_ready_o),
      .out_valid_o (issue.valid),
      .out_ready_i (issue.ready),
      .cas_o       (cas)
   );

   // Register reads are issued on the accept edge
   assign rs1_use = ~insn_imm18;
   assign rs2_use = ~insn_imm14 & ~insn_imm18;
   assign regf_rs1_re_o = cas & rs1_use;
   assign regf_rs1_addr_o = idu_insn_i[rs1_lsb +: ncpu_reg_aw];
   assign regf_rs2_re_o = cas & rs2_use;
   assign regf_rs2_addr_o = idu_insn_i[rs2_lsb +: ncpu_reg_aw];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         issue.lu_opc <= '0;
         issue.au_opc <= '0;
         issue.wb_regf <= 1'b0;
         rs1_frm_regf_r <= 1'b0;
         rs2_frm_regf_r <= 1'b0;
      end else if (cas) begin
         issue.lu_opc <= lu_opc;
         issue.au_opc <= au_opc;
         // Flushed or unknown ops still retire, without writeback
         issue.wb_regf <= insn_known & ~specul_flush_i;
         rs1_frm_regf_r <= rs1_use;
         rs2_frm_regf_r <= rs2_use;
      end
   end

   always_ff @(posedge clk) begin
      if (cas) begin
         imm_r <= imm_nxt;
         issue.wb_reg_addr <= idu_insn_i[rd_lsb +: ncpu_reg_aw];
      end
   end

   assign issue.operand_1 = rs1_frm_regf_r ? regf_rs1_dout_i : imm_r;
   assign issue.operand_2 = rs2_frm_regf_r ? regf_rs2_dout_i : imm_r;

endmodule

// File: hdl/ncpu32k_ieu.sv
// Execute unit. Logic and add/sub/MHI results retire in the cycle they
// are taken; divisions hold the operation until the divider is done.
module ncpu32k_ieu (
   input  logic                   clk,
   input  logic                   arst_n_i,
   ncpu32k_issue_if.ieu           issue,
   output logic                   regf_we_o,
   output ncpu32k_pkg::reg_addr_t regf_waddr_o,
   output ncpu32k_pkg::word_t     regf_wdata_o,
   output logic                   retire_o
);
   import ncpu32k_pkg::*;

   word_t opa;
   word_t opb;
   logic [ncpu_shw-1:0] shamt;
   logic div_sel;
   logic div_signed;
   logic div_req;
   logic div_start;
   logic div_last;
   logic div_busy;
   logic div_done;
   word_t quotient;
   word_t remainder;
   word_t result;

   assign opa = issue.operand_1;
   assign opb = issue.operand_2;
   assign shamt = opb[ncpu_shw-1:0];

   assign div_sel = issue.au_opc[au_div] | issue.au_opc[au_divu] |
                    issue.au_opc[au_mod] | issue.au_opc[au_modu];
   assign div_signed = issue.au_opc[au_div] | issue.au_opc[au_mod];
   assign div_req = issue.valid & div_sel & ~div_busy;

   always_comb begin
      if (issue.lu_opc[lu_and])
         result = opa & opb;
      else if (issue.lu_opc[lu_or])
         result = opa | opb;
      else if (issue.lu_opc[lu_xor])
         result = opa ^ opb;
      else if (issue.lu_opc[lu_lsl])
         result = opa << shamt;
      else if (issue.lu_opc[lu_lsr])
         result = opa >> shamt;
      else if (issue.lu_opc[lu_asr])
         result = word_t'($signed(opa) >>> shamt);
      else if (issue.au_opc[au_add])
         result = opa + opb;
      else if (issue.au_opc[au_sub])
         result = opa - opb;
      else if (issue.au_opc[au_mhi])
         result = opb << imm14_w;
      else if (issue.au_opc[au_div] | issue.au_opc[au_divu])
         result = quotient;
      else if (issue.au_opc[au_mod] | issue.au_opc[au_modu])
         result = remainder;
      else
         result = '0;
   end

   ncpu32k_div_fsm div_fsm (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_i    (div_req),
      .last_i   (div_last),
      .start_o  (div_start),
      .busy_o   (div_busy),
      .done_o   (div_done)
   );

   ncpu32k_div_cnt div_cnt (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .start_i  (div_start),
      .last_o   (div_last)
   );

   ncpu32k_div_dp div_dp (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .start_i     (div_start),
      .signed_i    (div_signed),
      .dividend_i  (opa),
      .divisor_i   (opb),
      .quotient_o  (quotient),
      .remainder_o (remainder)
   );

   // A division leaves the buffer only in the divider's done cycle
   assign issue.ready = ~div_sel | div_done;
   assign retire_o = issue.valid & issue.ready;
   assign regf_we_o = retire_o & issue.wb_regf;
   assign regf_waddr_o = issue.wb_reg_addr;
   assign regf_wdata_o = result;

endmodule

// File: hdl/ncpu32k_issue_if.sv
// Decoded operation from the decode unit to the execute unit.
// Transfers on an edge with valid and ready both high.
interface ncpu32k_issue_if;
   import ncpu32k_pkg::*;

   logic valid;
   logic ready;
   word_t operand_1;
   word_t operand_2;
   lu_opc_t lu_opc;
   au_opc_t au_opc;
   logic wb_regf;
   reg_addr_t wb_reg_addr;

   modport idu (
      output valid, operand_1, operand_2, lu_opc, au_opc, wb_regf, wb_reg_addr,
      input  ready
   );

   modport ieu (
      input  valid, operand_1, operand_2, lu_opc, au_opc, wb_regf, wb_reg_addr,
      output ready
   );

endinterface

// File: hdl/ncpu32k_pipebuf.sv
// One-entry valid/ready pipeline stage. cas_o marks the edge on which
// the owner should capture new payload.
module ncpu32k_pipebuf (
   input  logic clk,
   input  logic arst_n_i,
   input  logic in_valid_i,
   output logic in_ready_o,
   output logic out_valid_o,
   input  logic out_ready_i,
   output logic cas_o
);

   logic full_r;

   // Room when empty or when the held entry leaves on this edge
   assign in_ready_o = ~full_r | out_ready_i;
   assign cas_o = in_valid_i & in_ready_o;
   assign out_valid_o = full_r;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         full_r <= 1'b0;
      end else if (cas_o) begin
         full_r <= 1'b1;
      end else if (out_ready_i) begin
         full_r <= 1'b0;
      end
   end

endmodule

// File: hdl/ncpu32k_pkg.sv
// Shared widths, instruction field positions, opcodes and unit selects
// for the decode/execute slice. Every design module imports it.
package ncpu32k_pkg;

   localparam int ncpu_dw = 32;
   localparam int ncpu_reg_aw = 5;
   // Shift amount width, also the divider count width
   localparam int ncpu_shw = $clog2(ncpu_dw);

   typedef logic [ncpu_dw-1:0] word_t;
   typedef logic [ncpu_reg_aw-1:0] reg_addr_t;
   typedef logic [31:0] insn_t;

   // Instruction fields as low bit and width
   localparam int opc_lsb = 0;
   localparam int opc_w = 6;
   localparam int rd_lsb = 6;
   localparam int rs1_lsb = 12;
   localparam int rs2_lsb = 18;
   localparam int imm14_lsb = 18;
   localparam int imm14_w = 14;
   localparam int imm18_lsb = 12;
   localparam int imm18_w = 18;

   localparam logic [opc_w-1:0] op_and = 6'h01;
   localparam logic [opc_w-1:0] op_and_i = 6'h02;
   localparam logic [opc_w-1:0] op_or = 6'h03;
   localparam logic [opc_w-1:0] op_or_i = 6'h04;
   localparam logic [opc_w-1:0] op_xor = 6'h05;
   localparam logic [opc_w-1:0] op_xor_i = 6'h06;
   localparam logic [opc_w-1:0] op_lsl = 6'h07;
   localparam logic [opc_w-1:0] op_lsl_i = 6'h08;
   localparam logic [opc_w-1:0] op_lsr = 6'h09;
   localparam logic [opc_w-1:0] op_lsr_i = 6'h0a;
   localparam logic [opc_w-1:0] op_asr = 6'h0b;
   localparam logic [opc_w-1:0] op_asr_i = 6'h0c;
   localparam logic [opc_w-1:0] op_add = 6'h0d;
   localparam logic [opc_w-1:0] op_add_i = 6'h0e;
   localparam logic [opc_w-1:0] op_sub = 6'h0f;
   localparam logic [opc_w-1:0] op_mhi = 6'h10;
   localparam logic [opc_w-1:0] op_div = 6'h11;
   localparam logic [opc_w-1:0] op_divu = 6'h12;
   localparam logic [opc_w-1:0] op_mod = 6'h13;
   localparam logic [opc_w-1:0] op_modu = 6'h14;

   // One-hot logic unit select
   localparam int lu_opw = 6;
   localparam int lu_and = 0;
   localparam int lu_or = 1;
   localparam int lu_xor = 2;
   localparam int lu_lsl = 3;
   localparam int lu_lsr = 4;
   localparam int lu_asr = 5;
   typedef logic [lu_opw-1:0] lu_opc_t;

   // One-hot arithmetic unit select
   localparam int au_opw = 7;
   localparam int au_add = 0;
   localparam int au_sub = 1;
   localparam int au_mhi = 2;
   localparam int au_div = 3;
   localparam int au_divu = 4;
   localparam int au_mod = 5;
   localparam int au_modu = 6;
   typedef logic [au_opw-1:0] au_opc_t;

   typedef logic [ncpu_shw-1:0] div_cnt_t;
   typedef enum logic [1:0] {div_idle, div_run, div_done} div_state_e;

endpackage

// File: hdl/ncpu32k_regfile.sv
// 32 x 32 register file, two registered read ports and one write port.
// Register 0 reads as zero; a same-edge write is forwarded to the read.
module ncpu32k_regfile (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   rs1_re_i,
   input  ncpu32k_pkg::reg_addr_t rs1_addr_i,
   output ncpu32k_pkg::word_t     rs1_dout_o,
   input  logic                   rs2_re_i,
   input  ncpu32k_pkg::reg_addr_t rs2_addr_i,
   output ncpu32k_pkg::word_t     rs2_dout_o,
   input  logic                   we_i,
   input  ncpu32k_pkg::reg_addr_t waddr_i,
   input  ncpu32k_pkg::word_t     wdata_i
);
   import ncpu32k_pkg::*;

   word_t regs [2**ncpu_reg_aw];

   // Value a read of addr captures on this edge
   function automatic word_t rd_val(reg_addr_t addr);
      if (addr == '0)
         return '0;
      if (we_i && waddr_i == addr)
         return wdata_i;
      return regs[addr];
   endfunction

   always_ff @(posedge clk) begin
      if (we_i && waddr_i != '0) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // Outputs hold until the next enabled read
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rs1_dout_o <= '0;
         rs2_dout_o <= '0;
      end else begin
         if (rs1_re_i)
            rs1_dout_o <= rd_val(rs1_addr_i);
         if (rs2_re_i)
            rs2_dout_o <= rd_val(rs2_addr_i);
      end
   end

endmodule

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; a failing run exits nonzero.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_ncpu32k_core -f files.f -o sim_ncpu32k_core
./obj_dir/sim_ncpu32k_core

// File: tests/ncpu32k_core_sva.sv
// Handshake and retirement rules of the slice top level, bound into
// every ncpu32k_core instance.
module ncpu32k_core_sva (
   input logic                    clk,
   input logic                    arst_n_i,
   input logic                    insn_valid_i,
   input logic                    insn_ready_i,
   input logic                    retire_i,
   input logic                    wb_valid_i,
   input ncpu32k_pkg::div_state_e div_state_i
);
   import ncpu32k_pkg::*;

   logic accept;
   // Accepted but not yet retired, two at most
   logic [1:0] inflight;

   assign accept = insn_valid_i & insn_ready_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i)
         inflight <= '0;
      else
         inflight <= inflight + {1'b0, accept} - {1'b0, retire_i};
   end

   retire_has_insn: assert property (@(posedge clk) disable iff (!arst_n_i)
      retire_i |-> inflight != 2'd0)
      else $error("retire_o with no accepted instruction outstanding");

   inflight_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
      inflight != 2'd3)
      else $error("more than two instructions in flight");

   wb_needs_retire: assert property (@(posedge clk) disable iff (!arst_n_i)
      wb_valid_i |-> retire_i)
      else $error("wb_valid_o high without retire_o");

   stall_in_div: assert property (@(posedge clk) disable iff (!arst_n_i)
      div_state_i == div_run |-> !insn_ready_i)
      else $error("insn_ready_o high while the divider runs");

endmodule

bind ncpu32k_core ncpu32k_core_sva sva (
   .clk          (clk),
   .arst_n_i     (arst_n_i),
   .insn_valid_i (insn_valid_i),
   .insn_ready_i (insn_ready_o),
   .retire_i     (retire_o),
   .wb_valid_i   (wb_valid_o),
   .div_state_i  (ieu.div_fsm.state)
);

// File: tests/tb_ncpu32k_core.sv
// Random-program testbench for the decode/execute slice. A reference model
// predicts each retirement in acceptance order and retire_o is checked
// against it. Directed corner cases run first, then the random program.
module tb_ncpu32k_core;
   import ncpu32k_pkg::*;

   typedef struct packed {
      logic wb;
      reg_addr_t addr;
      word_t data;
   } expect_t;

   localparam int ready_timeout = 200;
   localparam int drain_timeout = 200;
   localparam int n_random = 400;

   logic clk;
   logic arst_n_i;
   logic insn_valid_i;
   logic insn_ready_o;
   insn_t insn_i;
   logic flush_i;
   logic retire_o;
   logic wb_valid_o;
   reg_addr_t wb_addr_o;
   word_t wb_data_o;

   integer seed;
   word_t model_regs [32];
   expect_t exp_q [$];

   ncpu32k_core UUT (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .insn_valid_i (insn_valid_i),
      .insn_ready_o (insn_ready_o),
      .insn_i       (insn_i),
      .flush_i      (flush_i),
      .retire_o     (retire_o),
      .wb_valid_o   (wb_valid_o),
      .wb_addr_o    (wb_addr_o),
      .wb_data_o    (wb_data_o)
   );

   always #4 clk = ~clk;

   task automatic die(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // Quotient truncates toward zero, remainder keeps the dividend's sign
   function automatic word_t div_model(word_t a, word_t b, logic is_signed, logic want_rem);
      longint sa;
      longint sb;
      if (b == '0)
         return want_rem ? a : '1;
      if (is_signed) begin
         sa = longint'($signed(a));
         sb = longint'($signed(b));
      end else begin
         sa = longint'({32'b0, a});
         sb = longint'({32'b0, b});
      end
      return want_rem ? word_t'(sa % sb) : word_t'(sa / sb);
   endfunction

   function automatic logic known_op(logic [5:0] opc);
      return opc inside {op_and, op_and_i, op_or, op_or_i, op_xor, op_xor_i, op_lsl,
                         op_lsl_i, op_lsr, op_lsr_i, op_asr, op_asr_i, op_add, op_add_i,
                         op_sub, op_mhi, op_div, op_divu, op_mod, op_modu};
   endfunction

   // Result from the instruction fields and the model's registers
   function automatic word_t exec_model(insn_t insn);
      word_t a;
      word_t b;
      word_t sx14;
      word_t zx14;
      a = model_regs[insn[16:12]];
      b = model_regs[insn[22:18]];
      sx14 = {{18{insn[31]}}, insn[31:18]};
      zx14 = {18'b0, insn[31:18]};
      case (insn[5:0])
         op_and:   return a & b;
         op_and_i: return a & sx14;
         op_or:    return a | b;
         op_or_i:  return a | zx14;
         op_xor:   return a ^ b;
         op_xor_i: return a ^ sx14;
         op_lsl:   return a << b[4:0];
         op_lsl_i: return a << zx14[4:0];
         op_lsr:   return a >> b[4:0];
         op_lsr_i: return a >> zx14[4:0];
         op_asr:   return word_t'($signed(a) >>> b[4:0]);
         op_asr_i: return word_t'($signed(a) >>> zx14[4:0]);
         op_add:   return a + b;
         op_add_i: return a + sx14;
         op_sub:   return a - b;
         op_mhi:   return {insn[29:12], 14'b0};
         op_div:   return div_model(a, b, 1'b1, 1'b0);
         op_divu:  return div_model(a, b, 1'b0, 1'b0);
         op_mod:   return div_model(a, b, 1'b1, 1'b1);
         op_modu:  return div_model(a, b, 1'b0, 1'b1);
         default:  return '0;
      endcase
   endfunction

   task automatic accept_model(insn_t insn, logic flush);
      expect_t e;
      e.wb = known_op(insn[5:0]) && !flush;
      e.addr = insn[10:6];
      e.data = exec_model(insn);
      if (e.wb && e.addr != '0)
         model_regs[e.addr] = e.data;
      exp_q.push_back(e);
   endtask

   task automatic check_retire();
      expect_t e;
      if (retire_o) begin
         assert (exp_q.size() != 0)
         else die("retire_o pulsed with no accepted instruction outstanding");
         e = exp_q.pop_front();
         assert (wb_valid_o === e.wb)
         else die($sformatf("Mismatch at %0t: wb_valid_o is %b, expected %b",
                            $time, wb_valid_o, e.wb));
         if (e.wb) begin
            assert (wb_addr_o === e.addr)
            else die($sformatf("Mismatch at %0t: wb_addr_o is %0d, expected %0d",
                               $time, wb_addr_o, e.addr));
            assert (wb_data_o === e.data)
            else die($sformatf("Mismatch at %0t: wb_data_o is %h, expected %h",
                               $time, wb_data_o, e.data));
         end
      end
   endtask

   // Outputs only change on the rising edge, so the falling edge sees them settled
   task automatic advance();
      @(negedge clk);
      check_retire();
   endtask

   // Holds the instruction on the bus until the DUT takes it
   task automatic send(insn_t insn, logic flush);
      int waited;
      insn_valid_i = 1'b1;
      insn_i = insn;
      flush_i = flush;
      waited = 0;
      while (!insn_ready_o) begin
         advance();
         waited++;
         if (waited > ready_timeout)
            die("Timeout while insn_ready_o stayed low");
      end
      accept_model(insn, flush);
      advance();
      insn_valid_i = 1'b0;
      flush_i = 1'b0;
   endtask

   function automatic insn_t enc_rrr(logic [5:0] opc, reg_addr_t rd, reg_addr_t rs1,
                                     reg_addr_t rs2);
      insn_t i;
      i = '0;
      i[5:0] = opc;
      i[10:6] = rd;
      i[16:12] = rs1;
      i[22:18] = rs2;
      return i;
   endfunction

   function automatic insn_t enc_rri(logic [5:0] opc, reg_addr_t rd, reg_addr_t rs1,
                                     logic [13:0] imm);
      insn_t i;
      i = '0;
      i[5:0] = opc;
      i[10:6] = rd;
      i[16:12] = rs1;
      i[31:18] = imm;
      return i;
   endfunction

   function automatic insn_t enc_mhi(reg_addr_t rd, logic [17:0] imm);
      insn_t i;
      i = '0;
      i[5:0] = op_mhi;
      i[10:6] = rd;
      i[29:12] = imm;
      return i;
   endfunction

   // Mostly a small window of registers so results feed later operands
   function automatic reg_addr_t pick_reg();
      logic [31:0] v;
      v = $random(seed);
      return (v[4:3] == 2'b00) ? v[9:5] : {2'b00, v[2:0]};
   endfunction

   function automatic insn_t rand_insn();
      logic [31:0] v;
      logic [5:0] opc;
      insn_t i;
      v = $random(seed);
      if (v % 10 == 0)
         opc = v[8] ? 6'h00 : 6'h15 + v[15:10] % 6'd43;
      else
         opc = 6'd1 + v[15:10] % 6'd20;
      i = $random(seed);
      i[5:0] = opc;
      i[10:6] = pick_reg();
      if (opc != op_mhi)
         i[16:12] = pick_reg();
      if (opc inside {op_and, op_or, op_xor, op_lsl, op_lsr, op_asr, op_add, op_sub,
                      op_div, op_divu, op_mod, op_modu})
         i[22:18] = pick_reg();
      return i;
   endfunction

   initial begin
      logic [31:0] v;
      int gap;
      int r;
      int n;
      int waited;
      seed = 32'hd37c5b27;
      clk = 1'b0;
      arst_n_i = 1'b0;
      insn_valid_i = 1'b0;
      insn_i = '0;
      flush_i = 1'b0;
      for (r = 0; r < 32; r++)
         model_regs[r] = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n_i = 1'b1;

      // Register storage powers up unknown
      for (r = 1; r < 32; r++) begin
         v = $random(seed);
         send(enc_mhi(reg_addr_t'(r), v[17:0]), 1'b0);
         send(enc_rri(op_or_i, reg_addr_t'(r), reg_addr_t'(r), v[31:18]), 1'b0);
      end

      // Most negative over -1, then zero divisors
      send(enc_mhi(5'd1, 18'h20000), 1'b0);
      send(enc_rri(op_add_i, 5'd2, 5'd0, 14'h3fff), 1'b0);
      send(enc_rrr(op_div, 5'd3, 5'd1, 5'd2), 1'b0);
      send(enc_rrr(op_mod, 5'd4, 5'd1, 5'd2), 1'b0);
      send(enc_rrr(op_divu, 5'd5, 5'd1, 5'd2), 1'b0);
      send(enc_rrr(op_modu, 5'd6, 5'd2, 5'd1), 1'b0);
      send(enc_rrr(op_div, 5'd7, 5'd1, 5'd0), 1'b0);
      send(enc_rrr(op_mod, 5'd8, 5'd2, 5'd0), 1'b0);
      send(enc_rrr(op_divu, 5'd9, 5'd2, 5'd0), 1'b0);
      send(enc_rrr(op_modu, 5'd10, 5'd1, 5'd0), 1'b0);
      // Dependent chain straight after a division
      send(enc_rrr(op_add, 5'd11, 5'd3, 5'd4), 1'b0);
      send(enc_rrr(op_sub, 5'd12, 5'd11, 5'd1), 1'b0);
      // r0 stays zero, a flushed write leaves r13 alone
      send(enc_rri(op_add_i, 5'd0, 5'd2, 14'h0005), 1'b0);
      send(enc_rrr(op_or, 5'd13, 5'd0, 5'd0), 1'b0);
      send(enc_rri(op_add_i, 5'd13, 5'd2, 14'h0007), 1'b1);
      send(enc_rrr(op_xor, 5'd14, 5'd13, 5'd0), 1'b0);
      send(enc_rrr(6'h3f, 5'd15, 5'd2, 5'd2), 1'b0);

      for (n = 0; n < n_random; n++) begin
         v = $random(seed);
         gap = (v[1:0] == 2'b00) ? int'(v[3:2]) + 1 : 0;
         repeat (gap) advance();
         send(rand_insn(), v[31:8] % 10 == 0);
      end

      waited = 0;
      while (exp_q.size() != 0) begin
         advance();
         waited++;
         if (waited > drain_timeout)
            die("Timeout while instructions were still outstanding at the end");
      end
      // A stray retire here would hit an empty queue
      repeat (4) advance();

      $display("TEST PASSED");
      $finish;
   end

endmodule
